// ==== common/noc_pkg.sv ====
// ********************
// NoC shared definitions
// Flit field widths, output directions and
// wormhole lock states for the mesh router port
// ********************

package noc_pkg;

  // Output directions of a 2D-mesh router
  localparam int NumRoutes = 5;

  // Width of one mesh coordinate (X or Y)
  localparam int CoordWidth = 3;

  // Width of the flit payload
  localparam int PayloadWidth = 16;

  // Width of a route index
  localparam int RouteIdxWidth = 3;

  // Route index, encoded as in the XY port map
  // Y decreasing is South, X decreasing is West
  typedef enum logic [RouteIdxWidth-1:0] {
    Eject = 3'd0,
    South = 3'd1,
    West  = 3'd2,
    North = 3'd3,
    East  = 3'd4
  } route_e;

  // Wormhole lock held between head and tail flit
  typedef enum logic {
    Unlocked = 1'b0,
    Locked   = 1'b1
  } lock_state_e;

endpackage

// ==== hdl/flit_fifo.sv ====
// ********************
// Flit FIFO
// Circular input buffer for flits, head
// flit shown on the read side
// ********************

`timescale 1ns/1ps

module flit_fifo
  import noc_pkg::*;
#(
  parameter int FifoDepth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    wr_en_i,
  input  logic [CoordWidth-1:0]   wr_dst_x_i,
  input  logic [CoordWidth-1:0]   wr_dst_y_i,
  input  logic                    wr_last_i,
  input  logic [PayloadWidth-1:0] wr_payload_i,
  output logic                    full_o,
  output logic                    head_valid_o,
  input  logic                    rd_en_i,
  output logic [CoordWidth-1:0]   head_dst_x_o,
  output logic [CoordWidth-1:0]   head_dst_y_o,
  output logic                    head_last_o,
  output logic [PayloadWidth-1:0] head_payload_o
);

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntWidth = $clog2(FifoDepth + 1);

  logic [CoordWidth-1:0]   mem_dst_x   [FifoDepth];
  logic [CoordWidth-1:0]   mem_dst_y   [FifoDepth];
  logic                    mem_last    [FifoDepth];
  logic [PayloadWidth-1:0] mem_payload [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                wr_fire;
  logic                rd_fire;

  // Writes into a full buffer and reads from an empty one are dropped
  assign wr_fire = wr_en_i && !full_o;
  assign rd_fire = rd_en_i && head_valid_o;

  assign full_o       = (count_q == CntWidth'(FifoDepth));
  assign head_valid_o = (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (wr_fire && !rd_fire) begin
        count_q <= count_q + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_dst_x[wr_ptr_q]   <= wr_dst_x_i;
      mem_dst_y[wr_ptr_q]   <= wr_dst_y_i;
      mem_last[wr_ptr_q]    <= wr_last_i;
      mem_payload[wr_ptr_q] <= wr_payload_i;
    end
  end

  assign head_dst_x_o   = mem_dst_x[rd_ptr_q];
  assign head_dst_y_o   = mem_dst_y[rd_ptr_q];
  assign head_last_o    = mem_last[rd_ptr_q];
  assign head_payload_o = mem_payload[rd_ptr_q];

endmodule

// ==== hdl/credit_counter.sv ====
// ********************
// Credit counter
// Tracks free slots in one downstream buffer
// ********************

`timescale 1ns/1ps

module credit_counter #(
  parameter int MaxCredits = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic send_i,
  input  logic credit_i,
  output logic has_credit_o
);

  localparam int CntWidth = $clog2(MaxCredits + 1);

  logic [CntWidth-1:0] count_q;

  // Starts full, one credit per downstream slot
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= CntWidth'(MaxCredits);
    end else begin
      case ({send_i, credit_i})
        2'b10: begin
          if (count_q != '0) begin
            count_q <= count_q - 1'b1;
          end
        end
        2'b01: begin
          // Saturate, extra credits are dropped
          if (count_q != CntWidth'(MaxCredits)) begin
            count_q <= count_q + 1'b1;
          end
        end
        default: count_q <= count_q;
      endcase
    end
  end

  assign has_credit_o = (count_q != '0);

endmodule

// ==== route_select/xy_route_select.sv ====
// ********************
// XY route select
// Dimension-ordered routing, X is resolved
// before Y, result as index and one-hot
// ********************

`timescale 1ns/1ps

module xy_route_select
  import noc_pkg::*;
(
  input  logic [CoordWidth-1:0] router_x_i,
  input  logic [CoordWidth-1:0] router_y_i,
  input  logic [CoordWidth-1:0] dst_x_i,
  input  logic [CoordWidth-1:0] dst_y_i,
  output route_e                route_o,
  output logic [NumRoutes-1:0]  route_onehot_o
);

  route_e route_sel;

  always_comb begin
    route_sel = East;
    if (dst_x_i == router_x_i && dst_y_i == router_y_i) begin
      route_sel = Eject;
    end else if (dst_x_i == router_x_i) begin
      // X done, move along Y
      if (dst_y_i < router_y_i) begin
        route_sel = South;
      end else begin
        route_sel = North;
      end
    end else begin
      if (dst_x_i < router_x_i) begin
        route_sel = West;
      end else begin
        route_sel = East;
      end
    end
  end

  assign route_o = route_sel;

  // One-hot decode of the selected direction
  always_comb begin
    route_onehot_o = '0;
    route_onehot_o[route_sel] = 1'b1;
  end

endmodule

// ==== route_select/wormhole_lock_fsm.sv ====
// ********************
// Wormhole lock FSM
// Holds the head flit's route until the
// tail flit of the packet has been sent
// ********************

`timescale 1ns/1ps

module wormhole_lock_fsm
  import noc_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  route_e route_i,
  input  logic   send_i,
  input  logic   last_i,
  output route_e route_o
);

  lock_state_e state_q;
  lock_state_e state_d;
  route_e      route_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Unlocked: begin
        // Head of a multi-flit packet takes the lock
        if (send_i && !last_i) begin
          state_d = Locked;
        end
      end
      Locked: begin
        if (send_i && last_i) begin
          state_d = Unlocked;
        end
      end
      default: state_d = Unlocked;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Unlocked;
    end else begin
      state_q <= state_d;
    end
  end

  // Route of the head flit, captured on its send
  always_ff @(posedge clk_i) begin
    if (state_q == Unlocked && send_i) begin
      route_q <= route_i;
    end
  end

  // Body flits ignore their own coordinates
  assign route_o = (state_q == Locked) ? route_q : route_i;

endmodule

// ==== hdl/router_in_port.sv ====
// ********************
// Router input port
// Buffers flits, routes them by XY, keeps
// the wormhole lock and checks credits
// ********************

`timescale 1ns/1ps

module router_in_port
  import noc_pkg::*;
#(
  parameter int FifoDepth  = 4,
  parameter int MaxCredits = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [CoordWidth-1:0]   router_x_i,
  input  logic [CoordWidth-1:0]   router_y_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic [CoordWidth-1:0]   in_dst_x_i,
  input  logic [CoordWidth-1:0]   in_dst_y_i,
  input  logic                    in_last_i,
  input  logic [PayloadWidth-1:0] in_payload_i,
  output logic [NumRoutes-1:0]    out_valid_o,
  output logic [CoordWidth-1:0]   out_dst_x_o,
  output logic [CoordWidth-1:0]   out_dst_y_o,
  output logic                    out_last_o,
  output logic [PayloadWidth-1:0] out_payload_o,
  input  logic [NumRoutes-1:0]    credit_i
);

  logic                    fifo_full;
  logic                    head_valid;
  logic [CoordWidth-1:0]   head_dst_x;
  logic [CoordWidth-1:0]   head_dst_y;
  logic                    head_last;
  logic [PayloadWidth-1:0] head_payload;
  route_e                  route_comp;
  route_e                  route_eff;
  logic [NumRoutes-1:0]    route_eff_onehot;
  logic [NumRoutes-1:0]    has_credit;
  logic                    send;

  assign in_ready_o = !fifo_full;

  flit_fifo #(
    .FifoDepth (FifoDepth)
  ) flit_fifo_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wr_en_i        (in_valid_i && in_ready_o),
    .wr_dst_x_i     (in_dst_x_i),
    .wr_dst_y_i     (in_dst_y_i),
    .wr_last_i      (in_last_i),
    .wr_payload_i   (in_payload_i),
    .full_o         (fifo_full),
    .head_valid_o   (head_valid),
    .rd_en_i        (send),
    .head_dst_x_o   (head_dst_x),
    .head_dst_y_o   (head_dst_y),
    .head_last_o    (head_last),
    .head_payload_o (head_payload)
  );

  // Only the index form is needed, the locked route is decoded below
  xy_route_select xy_route_select_inst (
    .router_x_i     (router_x_i),
    .router_y_i     (router_y_i),
    .dst_x_i        (head_dst_x),
    .dst_y_i        (head_dst_y),
    .route_o        (route_comp),
    .route_onehot_o ()
  );

  wormhole_lock_fsm wormhole_lock_fsm_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .route_i (route_comp),
    .send_i  (send),
    .last_i  (head_last),
    .route_o (route_eff)
  );

  // One counter per output direction
  for (genvar r = 0; r < NumRoutes; r++) begin : gen_credit
    credit_counter #(
      .MaxCredits (MaxCredits)
    ) credit_counter_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .send_i       (out_valid_o[r]),
      .credit_i     (credit_i[r]),
      .has_credit_o (has_credit[r])
    );
  end

  assign route_eff_onehot = NumRoutes'(1) << route_eff;

  // Head leaves only if the chosen downstream buffer has room
  assign send        = head_valid && has_credit[route_eff];
  assign out_valid_o = send ? route_eff_onehot : '0;

  assign out_dst_x_o   = head_dst_x;
  assign out_dst_y_o   = head_dst_y;
  assign out_last_o    = head_last;
  assign out_payload_o = head_payload;

endmodule

// ==== verification/router_in_port_sva.sv ====
// ********************
// Router input port assertions
// One-hot output, credit and back-pressure rules
// ********************

`timescale 1ns/1ps

module router_in_port_sva
  import noc_pkg::*;
#(
  parameter int FifoDepth = 4
) (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 in_valid_i,
  input logic [NumRoutes-1:0] out_valid_i,
  input logic                 in_ready_i,
  input logic [NumRoutes-1:0] has_credit_i
);

  // Number of failed properties
  int fail_count = 0;

  // Flits held in the port, counted from the link handshakes
  int occ_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      occ_q <= 0;
    end else begin
      occ_q <= occ_q + int'(in_valid_i && in_ready_i) - int'(out_valid_i != '0);
    end
  end

  a_out_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(out_valid_i))
    else begin
      fail_count++;
      $error("out_valid_o has more than one output set");
    end

  // An output without credit stays quiet
  a_credit: assert property (@(posedge clk_i) disable iff (rst_i)
                             (out_valid_i & ~has_credit_i) == '0)
    else begin
      fail_count++;
      $error("flit sent on an output whose credit count is zero");
    end

  a_ready_full: assert property (@(posedge clk_i) disable iff (rst_i)
                                 (occ_q >= FifoDepth) |-> !in_ready_i)
    else begin
      fail_count++;
      $error("in_ready_o high while the FIFO is full");
    end

endmodule

bind router_in_port router_in_port_sva #(
  .FifoDepth (FifoDepth)
) router_in_port_sva_inst (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .in_valid_i   (in_valid_i),
  .out_valid_i  (out_valid_o),
  .in_ready_i   (in_ready_o),
  .has_credit_i (has_credit)
);

// ==== verification/router_in_port_tb.sv ====
// ********************
// Router input port testbench
// Random packets from an LFSR, checked cycle by
// cycle against a queue and credit model
// ********************

`timescale 1ns/1ps

module router_in_port_tb
  import noc_pkg::*;
;

  localparam int ClkPeriod      = 100;
  localparam int FifoDepth      = 4;
  localparam int MaxCredits     = 4;
  localparam int NumPackets     = 80;
  localparam int MaxPktLen      = 4;
  localparam int FlitCycleBound = 20;
  localparam int HoldStart      = 150;
  localparam int HoldCycles     = 150;
  localparam int TimeoutCycles  = NumPackets * MaxPktLen * FlitCycleBound + HoldCycles + 20;

  // Model flit layout: route, last, dst_x, dst_y, payload
  localparam int FlitWidth = RouteIdxWidth + 1 + 2 * CoordWidth + PayloadWidth;
  localparam int YLsb      = PayloadWidth;
  localparam int XLsb      = YLsb + CoordWidth;
  localparam int LastBit   = XLsb + CoordWidth;
  localparam int RouteLsb  = LastBit + 1;

  logic                    clk_i;
  logic                    rst_i;
  logic [CoordWidth-1:0]   router_x_i;
  logic [CoordWidth-1:0]   router_y_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  logic [CoordWidth-1:0]   in_dst_x_i;
  logic [CoordWidth-1:0]   in_dst_y_i;
  logic                    in_last_i;
  logic [PayloadWidth-1:0] in_payload_i;
  logic [NumRoutes-1:0]    out_valid_o;
  logic [CoordWidth-1:0]   out_dst_x_o;
  logic [CoordWidth-1:0]   out_dst_y_o;
  logic                    out_last_o;
  logic [PayloadWidth-1:0] out_payload_o;
  logic [NumRoutes-1:0]    credit_i;

  logic [15:0]          lfsr_q;
  logic [FlitWidth-1:0] gen_q[$];
  logic [FlitWidth-1:0] model_q[$];
  logic [FlitWidth-1:0] cur_flit;
  int                   credit_due[NumRoutes][$];
  int                   model_credit[NumRoutes];
  int                   outstanding[NumRoutes];
  logic                 have_flit;
  logic                 saw_full;
  int                   gap;
  int                   cycle;
  int                   pkts_made;
  int                   accepted;
  int                   sent;
  int                   errors;
  int                   sva_errors;

  router_in_port #(
    .FifoDepth  (FifoDepth),
    .MaxCredits (MaxCredits)
  ) router_in_port_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .router_x_i    (router_x_i),
    .router_y_i    (router_y_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_dst_x_i    (in_dst_x_i),
    .in_dst_y_i    (in_dst_y_i),
    .in_last_i     (in_last_i),
    .in_payload_i  (in_payload_i),
    .out_valid_o   (out_valid_o),
    .out_dst_x_o   (out_dst_x_o),
    .out_dst_y_o   (out_dst_y_o),
    .out_last_o    (out_last_o),
    .out_payload_o (out_payload_o),
    .credit_i      (credit_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic int lfsr_bits(input int n);
    int   val;
    logic fb;
    val = 0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = (val << 1) | int'(fb);
    end
    return val;
  endfunction

  // X first, then Y
  function automatic route_e expected_route(input logic [CoordWidth-1:0] dx,
                                            input logic [CoordWidth-1:0] dy);
    if (dx == router_x_i && dy == router_y_i) return Eject;
    if (dx == router_x_i) return (dy < router_y_i) ? South : North;
    return (dx < router_x_i) ? West : East;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    assert (exp_v == got_v) else begin
      errors++;
      $display("[ERROR] %s exp=%0h got=%0h", name, exp_v, got_v);
    end
  endtask

  task automatic make_packet();
    int                      len;
    logic [CoordWidth-1:0]   hx;
    logic [CoordWidth-1:0]   hy;
    logic [CoordWidth-1:0]   fx;
    logic [CoordWidth-1:0]   fy;
    logic [PayloadWidth-1:0] pl;
    route_e                  r;
    len = lfsr_bits(2) + 1;
    hx  = CoordWidth'(lfsr_bits(CoordWidth));
    hy  = CoordWidth'(lfsr_bits(CoordWidth));
    r   = expected_route(hx, hy);
    for (int i = 0; i < len; i++) begin
      fx = hx;
      fy = hy;
      if (i > 0) begin
        // Body coordinates point elsewhere on purpose
        fx = hx ^ CoordWidth'(lfsr_bits(CoordWidth) | 1);
        fy = CoordWidth'(lfsr_bits(CoordWidth));
      end
      pl = PayloadWidth'(lfsr_bits(PayloadWidth));
      gen_q.push_back({r, (i == len - 1), fx, fy, pl});
    end
    pkts_made++;
  endtask

  // Holds a raised valid until the flit is taken
  task automatic drive_input();
    if (gap > 0) begin
      gap--;
      in_valid_i = 1'b0;
    end else begin
      if (!have_flit) begin
        if (gen_q.size() == 0 && pkts_made < NumPackets) make_packet();
        if (gen_q.size() > 0) begin
          cur_flit  = gen_q.pop_front();
          have_flit = 1'b1;
        end
      end
      in_valid_i   = have_flit;
      in_dst_x_i   = cur_flit[XLsb +: CoordWidth];
      in_dst_y_i   = cur_flit[YLsb +: CoordWidth];
      in_last_i    = cur_flit[LastBit];
      in_payload_i = cur_flit[PayloadWidth-1:0];
    end
    if (in_valid_i && in_ready_o) begin
      model_q.push_back(cur_flit);
      accepted++;
      have_flit = 1'b0;
      gap       = lfsr_bits(2);
    end
  endtask

  task automatic run_cycle();
    logic [FlitWidth-1:0] head;
    route_e               r;
    logic [NumRoutes-1:0] exp_valid;
    logic [NumRoutes-1:0] cred;
    logic                 holding;
    holding   = (cycle >= HoldStart) && (cycle < HoldStart + HoldCycles);
    exp_valid = '0;
    head      = '0;
    r         = Eject;
    if (model_q.size() > 0) begin
      head = model_q[0];
      r    = route_e'(head[RouteLsb +: RouteIdxWidth]);
      if (model_credit[r] > 0) exp_valid = NumRoutes'(1) << r;
    end
    check_value("in_ready_o", 32'(model_q.size() < FifoDepth), 32'(in_ready_o));
    check_value("out_valid_o", 32'(exp_valid), 32'(out_valid_o));
    if (exp_valid != '0) begin
      check_value("out_dst_x_o", 32'(head[XLsb +: CoordWidth]), 32'(out_dst_x_o));
      check_value("out_dst_y_o", 32'(head[YLsb +: CoordWidth]), 32'(out_dst_y_o));
      check_value("out_last_o", 32'(head[LastBit]), 32'(out_last_o));
      check_value("out_payload_o", 32'(head[PayloadWidth-1:0]), 32'(out_payload_o));
      void'(model_q.pop_front());
      model_credit[r]--;
      credit_due[r].push_back(cycle + 1 + lfsr_bits(3));
    end
    // Flits the DUT actually emitted
    if (out_valid_o != '0) sent++;
    for (int i = 0; i < NumRoutes; i++) begin
      if (out_valid_o[i]) outstanding[i]++;
      assert (outstanding[i] <= MaxCredits) else begin
        errors++;
        $display("More flits sent on output %0d than it has credits for", i);
      end
    end
    if (holding && !in_ready_o) saw_full = 1'b1;
    // Return credits that have come due, one per output and cycle
    cred = '0;
    for (int i = 0; i < NumRoutes; i++) begin
      if (!holding && credit_due[i].size() > 0 && credit_due[i][0] <= cycle) begin
        cred[i] = 1'b1;
        void'(credit_due[i].pop_front());
        model_credit[i]++;
        outstanding[i]--;
      end
    end
    credit_i = cred;
    drive_input();
  endtask

  function automatic logic traffic_done();
    int pending;
    pending = 0;
    for (int i = 0; i < NumRoutes; i++) pending += credit_due[i].size();
    return pkts_made == NumPackets && gen_q.size() == 0 && !have_flit &&
           model_q.size() == 0 && pending == 0 && cycle >= HoldStart + HoldCycles;
  endfunction

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Watchdog expired before all flits were delivered");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    in_valid_i   = 1'b0;
    in_dst_x_i   = '0;
    in_dst_y_i   = '0;
    in_last_i    = 1'b0;
    in_payload_i = '0;
    credit_i     = '0;
    cur_flit     = '0;
    have_flit    = 1'b0;
    saw_full     = 1'b0;
    gap          = 0;
    cycle        = 0;
    pkts_made    = 0;
    accepted     = 0;
    sent         = 0;
    errors       = 0;
    lfsr_q       = 16'd39053;
    router_x_i   = CoordWidth'(lfsr_bits(CoordWidth));
    router_y_i   = CoordWidth'(lfsr_bits(CoordWidth));
    for (int i = 0; i < NumRoutes; i++) begin
      model_credit[i] = MaxCredits;
      outstanding[i]  = 0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_value("out_valid_o", 32'h0, 32'(out_valid_o));
    check_value("in_ready_o", 32'h1, 32'(in_ready_o));
    while (!traffic_done()) begin
      @(negedge clk_i);
      cycle++;
      run_cycle();
    end
    // Idle cycles, nothing may come out
    repeat (4) begin
      @(negedge clk_i);
      cycle++;
      run_cycle();
    end
    assert (saw_full) else begin
      errors++;
      $display("Input never stalled while credits were withheld");
    end
    assert (sent == accepted && model_q.size() == 0) else begin
      errors++;
      $display("Flits lost or duplicated, %0d accepted and %0d sent", accepted, sent);
    end
    sva_errors = router_in_port_inst.router_in_port_sva_inst.fail_count;
    $display("Errors: testbench %0d, assertions %0d (flits accepted %0d, sent %0d)",
             errors, sva_errors, accepted, sent);
    if (errors == 0 && sva_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
common/noc_pkg.sv
hdl/flit_fifo.sv
hdl/credit_counter.sv
route_select/xy_route_select.sv
route_select/wormhole_lock_fsm.sv
hdl/router_in_port.sv
verification/router_in_port_sva.sv
verification/router_in_port_tb.sv

// ==== Makefile ====
# Verilator build and run for the router input port

VERILATOR ?= verilator
TOP       ?= router_in_port_tb
FILELIST  ?= files.f
BUILD_DIR ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx 'TB PASSED' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
